// ==== Bender.yml ====
package:
  name: thumb_exec

sources:
  - files:
      - hdl/thumb_pkg.sv
      - hdl/cpu_controller.sv
      - hdl/ldm_stm_counter.sv
      - hdl/alu.sv
      - hdl/reg_file.sv
      - hdl/data_mem.sv
      - hdl/thumb_exec_top.sv
  - target: simulation
    files:
      - tb/tb_thumb_exec.sv

// ==== files.f ====
hdl/thumb_pkg.sv
hdl/cpu_controller.sv
hdl/ldm_stm_counter.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/data_mem.sv
hdl/thumb_exec_top.sv
tb/tb_thumb_exec.sv

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu import thumb_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  alu_op_e               op_i,
    input  logic [DATA_WIDTH-1:0] a_i,
    input  logic [DATA_WIDTH-1:0] b_i,
    input  logic                  update_flags_i,
    output logic [DATA_WIDTH-1:0] result_o,
    output logic [3:0]            flags_o
);

    logic [DATA_WIDTH:0] wide;
    logic                carry;
    logic                ovf;
    logic                arith;

    always_comb begin
        wide     = '0;
        result_o = '0;
        carry    = 1'b0;
        ovf      = 1'b0;
        arith    = 1'b0;
        case (op_i)
            ALU_ADD: begin
                wide     = {1'b0, a_i} + {1'b0, b_i};
                result_o = wide[DATA_WIDTH-1:0];
                carry    = wide[DATA_WIDTH];
                ovf      = (a_i[DATA_WIDTH-1] == b_i[DATA_WIDTH-1]) &&
                           (result_o[DATA_WIDTH-1] != a_i[DATA_WIDTH-1]);
                arith    = 1'b1;
            end
            ALU_SUB: begin
                // carry means no borrow
                wide     = {1'b0, a_i} - {1'b0, b_i};
                result_o = wide[DATA_WIDTH-1:0];
                carry    = ~wide[DATA_WIDTH];
                ovf      = (a_i[DATA_WIDTH-1] != b_i[DATA_WIDTH-1]) &&
                           (result_o[DATA_WIDTH-1] != a_i[DATA_WIDTH-1]);
                arith    = 1'b1;
            end
            ALU_LSL: result_o = a_i << b_i[4:0];
            ALU_LSR: result_o = a_i >> b_i[4:0];
            ALU_ASR: result_o = $unsigned($signed(a_i) >>> b_i[4:0]);
            default: ;
        endcase
    end

    // flags are N Z C V from the top bit down; shifts leave C and V alone
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            flags_o <= '0;
        end else if (update_flags_i) begin
            flags_o[3] <= result_o[DATA_WIDTH-1];
            flags_o[2] <= (result_o == '0);
            if (arith) begin
                flags_o[1:0] <= {carry, ovf};
            end
        end
    end

endmodule

// ==== hdl/cpu_controller.sv ====
`timescale 1ns/1ps

module cpu_controller import thumb_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  instr_u                  instr_i,
    input  logic                    instr_valid_i,
    input  logic [SLOT_WIDTH-1:0]   slot_i,
    input  logic [OFFSET_WIDTH-1:0] offset_i,
    output alu_op_e                 alu_op_o,
    output operand_src_e            op1_sel_o,
    output operand_src_e            op2_sel_o,
    output logic [DATA_WIDTH-1:0]   imm_o,
    output logic                    update_flags_o,
    output logic                    reg_write_en_o,
    output wb_src_e                 wb_sel_o,
    output logic [ADDR_WIDTH-1:0]   waddr_o,
    output logic [ADDR_WIDTH-1:0]   raddr1_o,
    output logic [ADDR_WIDTH-1:0]   raddr2_o,
    output logic                    mem_write_en_o,
    output logic                    count_en_o,
    output logic                    stall_o
);

    logic reg_we;
    logic mem_we;
    logic flags_we;
    logic multi;

    always_comb begin
        alu_op_o  = ALU_ADD;
        op1_sel_o = FROM_REG;
        op2_sel_o = FROM_REG;
        imm_o     = '0;
        wb_sel_o  = FROM_ALU;
        waddr_o   = ADDR_WIDTH'(instr_i.arith.r3.rd);
        raddr1_o  = ADDR_WIDTH'(instr_i.arith.r3.rn);
        raddr2_o  = ADDR_WIDTH'(instr_i.arith.r3.rm);
        reg_we    = 1'b0;
        mem_we    = 1'b0;
        flags_we  = 1'b0;
        multi     = 1'b0;

        // both views keep the major opcode in bits 15:11
        casez (instr_i.mult.op)
            SHIFT_IMM: begin
                reg_we   = 1'b1;
                flags_we = 1'b1;
                casez (instr_i.arith.r3.sub)
                    LEFT_SHIFT_L_IM, RIGHT_SHIFT_L_IM, RIGHT_SHIFT_A_IM: begin
                        if (instr_i.arith.r3.sub[4:2] == 3'b000) begin
                            alu_op_o = ALU_LSL;
                        end else if (instr_i.arith.r3.sub[4:2] == 3'b001) begin
                            alu_op_o = ALU_LSR;
                        end else begin
                            alu_op_o = ALU_ASR;
                        end
                        op2_sel_o = FROM_IMM;
                        imm_o     = DATA_WIDTH'(instr_i.arith.i5.imm5);
                        raddr1_o  = ADDR_WIDTH'(instr_i.arith.i5.rm);
                        waddr_o   = ADDR_WIDTH'(instr_i.arith.i5.rd);
                    end
                    ADD_REG: alu_op_o = ALU_ADD;
                    SUB_REG: alu_op_o = ALU_SUB;
                    ADD_3_IMM, SUB_3_IMM: begin
                        alu_op_o  = instr_i.arith.r3.sub[0] ? ALU_SUB : ALU_ADD;
                        op2_sel_o = FROM_IMM;
                        imm_o     = DATA_WIDTH'(instr_i.arith.i3.imm3);
                    end
                    MOV_8_IMM, CMP_8_IMM, ADD_8_IMM, SUB_8_IMM: begin
                        // the two low sub-code bits belong to rd here
                        op2_sel_o = FROM_IMM;
                        imm_o     = DATA_WIDTH'(instr_i.arith.i8.imm8);
                        raddr1_o  = ADDR_WIDTH'(instr_i.arith.i8.rd);
                        waddr_o   = ADDR_WIDTH'(instr_i.arith.i8.rd);
                        if (instr_i.arith.r3.sub[4:2] == 3'b100) begin
                            op1_sel_o = FROM_ZERO;
                        end
                        if (instr_i.arith.r3.sub[4:2] != 3'b110 &&
                            instr_i.arith.r3.sub[4:2] != 3'b100) begin
                            alu_op_o = ALU_SUB;
                        end
                        // compare only leaves its mark in the flags
                        if (instr_i.arith.r3.sub[4:2] == 3'b101) begin
                            reg_we = 1'b0;
                        end
                    end
                    default: ;
                endcase
            end

            STORE_MULT_REG: begin
                multi     = 1'b1;
                op2_sel_o = FROM_ACCUMULATOR;
                raddr1_o  = ADDR_WIDTH'(slot_i);
                raddr2_o  = ADDR_WIDTH'(instr_i.mult.base);
                mem_we    = instr_i.mult.reg_list[slot_i];
            end

            LOAD_MULT_REG: begin
                multi     = 1'b1;
                op2_sel_o = FROM_ACCUMULATOR;
                raddr2_o  = ADDR_WIDTH'(instr_i.mult.base);
                waddr_o   = ADDR_WIDTH'(slot_i);
                wb_sel_o  = FROM_MEM;
                reg_we    = instr_i.mult.reg_list[slot_i];
            end

            // everything else, including the first half of a 32-bit opcode, is a bubble
            default: ;
        endcase
    end

    assign reg_write_en_o = instr_valid_i & reg_we;
    assign mem_write_en_o = instr_valid_i & mem_we;
    assign update_flags_o = instr_valid_i & flags_we;
    assign count_en_o     = instr_valid_i & multi & (slot_i != MAX_COUNT);
    assign stall_o        = count_en_o;

    // a stalled transfer only finishes its writes if the source keeps the word in place
    a_held_while_stalled: assert property (@(posedge clk_i) disable iff (rst_i)
        stall_o |=> instr_valid_i && $stable(instr_i));

    // the sequencer can never have moved more registers than slots have passed
    a_offset_bounded: assert property (@(posedge clk_i) disable iff (rst_i)
        offset_i <= {slot_i, 2'b00});

endmodule

// ==== hdl/data_mem.sv ====
`timescale 1ns/1ps

module data_mem import thumb_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic [DATA_WIDTH-3:0] addr_i,
    input  logic [DATA_WIDTH-1:0] wdata_i,
    input  logic                  we_i,
    output logic [DATA_WIDTH-1:0] rdata_o
);

    logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we_i) begin
            mem[addr_i[MEM_ADDR_WIDTH-1:0]] <= wdata_i;
        end
    end

    assign rdata_o = mem[addr_i[MEM_ADDR_WIDTH-1:0]];

    // the word address comes from base plus offset and must land inside the array
    a_addr_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
        we_i |-> addr_i < MEM_WORDS);

endmodule

// ==== hdl/ldm_stm_counter.sv ====
`timescale 1ns/1ps

module ldm_stm_counter import thumb_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    count_en_i,
    input  logic [NUM_REGS-1:0]     reg_list_i,
    output logic [SLOT_WIDTH-1:0]   slot_o,
    output logic [OFFSET_WIDTH-1:0] offset_o
);

    // number of listed registers in the slots already passed
    logic [SLOT_WIDTH-1:0] moved;

    always_ff @(posedge clk_i) begin
        if (rst_i || !count_en_i) begin
            slot_o <= '0;
        end else begin
            slot_o <= slot_o + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || !count_en_i) begin
            moved <= '0;
        end else if (reg_list_i[slot_o]) begin
            moved <= moved + 1'b1;
        end
    end

    // each register is one 4-byte word
    assign offset_o = {moved, 2'b00};

    a_no_wrap: assert property (@(posedge clk_i) disable iff (rst_i)
        count_en_i |=> slot_o != '0);

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import thumb_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic [ADDR_WIDTH-1:0] raddr1_i,
    input  logic [ADDR_WIDTH-1:0] raddr2_i,
    input  logic [ADDR_WIDTH-1:0] dbg_addr_i,
    input  logic [ADDR_WIDTH-1:0] waddr_i,
    input  logic [DATA_WIDTH-1:0] wdata_i,
    input  logic                  we_i,
    output logic [DATA_WIDTH-1:0] rdata1_o,
    output logic [DATA_WIDTH-1:0] rdata2_o,
    output logic [DATA_WIDTH-1:0] dbg_data_o
);

    logic [DATA_WIDTH-1:0] regs [NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i < NUM_REGS) begin
            regs[waddr_i[SLOT_WIDTH-1:0]] <= wdata_i;
        end
    end

    // indices above the low eight registers read as zero
    assign rdata1_o   = (raddr1_i < NUM_REGS) ? regs[raddr1_i[SLOT_WIDTH-1:0]] : '0;
    assign rdata2_o   = (raddr2_i < NUM_REGS) ? regs[raddr2_i[SLOT_WIDTH-1:0]] : '0;
    assign dbg_data_o = (dbg_addr_i < NUM_REGS) ? regs[dbg_addr_i[SLOT_WIDTH-1:0]] : '0;

endmodule

// ==== hdl/thumb_exec_top.sv ====
`timescale 1ns/1ps

module thumb_exec_top import thumb_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  instr_u                instr_i,
    input  logic                  instr_valid_i,
    output logic                  stall_o,
    input  logic [ADDR_WIDTH-1:0] dbg_addr_i,
    output logic [DATA_WIDTH-1:0] dbg_data_o,
    output logic [3:0]            flags_o
);

    alu_op_e                 alu_op;
    operand_src_e            op1_sel;
    operand_src_e            op2_sel;
    wb_src_e                 wb_sel;
    logic [DATA_WIDTH-1:0]   imm;
    logic                    update_flags;
    logic                    reg_write_en;
    logic                    mem_write_en;
    logic                    count_en;
    logic [ADDR_WIDTH-1:0]   waddr;
    logic [ADDR_WIDTH-1:0]   raddr1;
    logic [ADDR_WIDTH-1:0]   raddr2;
    logic [SLOT_WIDTH-1:0]   slot;
    logic [OFFSET_WIDTH-1:0] offset;
    logic [DATA_WIDTH-1:0]   rdata1;
    logic [DATA_WIDTH-1:0]   rdata2;
    logic [DATA_WIDTH-1:0]   alu_a;
    logic [DATA_WIDTH-1:0]   alu_b;
    logic [DATA_WIDTH-1:0]   alu_result;
    logic [DATA_WIDTH-1:0]   mem_addr;
    logic [DATA_WIDTH-1:0]   mem_rdata;
    logic [DATA_WIDTH-1:0]   wb_data;

    function automatic logic [DATA_WIDTH-1:0] pick_operand(
        input operand_src_e          sel,
        input logic [DATA_WIDTH-1:0] reg_value,
        input logic [DATA_WIDTH-1:0] imm_value,
        input logic [DATA_WIDTH-1:0] acc_value
    );
        logic [DATA_WIDTH-1:0] value;
        case (sel)
            FROM_IMM:         value = imm_value;
            FROM_ZERO:        value = '0;
            FROM_ACCUMULATOR: value = acc_value;
            default:          value = reg_value;
        endcase
        return value;
    endfunction

    assign alu_a    = pick_operand(op1_sel, rdata1, imm, DATA_WIDTH'(offset));
    assign alu_b    = pick_operand(op2_sel, rdata2, imm, DATA_WIDTH'(offset));
    assign wb_data  = (wb_sel == FROM_MEM) ? mem_rdata : alu_result;
    // the base register sits on read port 2 during LDM and STM
    assign mem_addr = rdata2 + DATA_WIDTH'(offset);

    cpu_controller u_ctrl (
        .clk_i, .rst_i, .instr_i, .instr_valid_i,
        .slot_i(slot), .offset_i(offset),
        .alu_op_o(alu_op), .op1_sel_o(op1_sel), .op2_sel_o(op2_sel), .imm_o(imm),
        .update_flags_o(update_flags), .reg_write_en_o(reg_write_en), .wb_sel_o(wb_sel),
        .waddr_o(waddr), .raddr1_o(raddr1), .raddr2_o(raddr2),
        .mem_write_en_o(mem_write_en), .count_en_o(count_en), .stall_o
    );

    ldm_stm_counter u_counter (
        .clk_i, .rst_i, .count_en_i(count_en), .reg_list_i(instr_i.mult.reg_list),
        .slot_o(slot), .offset_o(offset)
    );

    alu u_alu (
        .clk_i, .rst_i, .op_i(alu_op), .a_i(alu_a), .b_i(alu_b),
        .update_flags_i(update_flags), .result_o(alu_result), .flags_o
    );

    reg_file u_regs (
        .clk_i, .rst_i, .raddr1_i(raddr1), .raddr2_i(raddr2), .dbg_addr_i,
        .waddr_i(waddr), .wdata_i(wb_data), .we_i(reg_write_en),
        .rdata1_o(rdata1), .rdata2_o(rdata2), .dbg_data_o
    );

    data_mem u_mem (
        .clk_i, .rst_i, .addr_i(mem_addr[DATA_WIDTH-1:2]), .wdata_i(rdata1),
        .we_i(mem_write_en), .rdata_o(mem_rdata)
    );

endmodule

// ==== hdl/thumb_pkg.sv ====
package thumb_pkg;

    localparam int unsigned DATA_WIDTH     = 32;
    localparam int unsigned ADDR_WIDTH     = 4;
    localparam int unsigned NUM_REGS       = 8;
    localparam int unsigned MEM_ADDR_WIDTH = 6;
    localparam int unsigned MEM_WORDS      = 2 ** MEM_ADDR_WIDTH;

    // transfer slots of LDM/STM, one per register of the list
    localparam int unsigned SLOT_WIDTH   = 3;
    localparam int unsigned OFFSET_WIDTH = SLOT_WIDTH + 2;
    localparam logic [SLOT_WIDTH-1:0] MAX_COUNT = 3'd7;

    // major opcodes live in bits 15:11
    localparam logic [4:0] SHIFT_IMM      = 5'b00???;
    localparam logic [4:0] STORE_MULT_REG = 5'b11000;
    localparam logic [4:0] LOAD_MULT_REG  = 5'b11001;

    // sub-codes of the shift/add/sub/move/compare class, bits 13:9
    localparam logic [4:0] LEFT_SHIFT_L_IM  = 5'b000??;
    localparam logic [4:0] RIGHT_SHIFT_L_IM = 5'b001??;
    localparam logic [4:0] RIGHT_SHIFT_A_IM = 5'b010??;
    localparam logic [4:0] ADD_REG          = 5'b01100;
    localparam logic [4:0] SUB_REG          = 5'b01101;
    localparam logic [4:0] ADD_3_IMM        = 5'b01110;
    localparam logic [4:0] SUB_3_IMM        = 5'b01111;
    localparam logic [4:0] MOV_8_IMM        = 5'b100??;
    localparam logic [4:0] CMP_8_IMM        = 5'b101??;
    localparam logic [4:0] ADD_8_IMM        = 5'b110??;
    localparam logic [4:0] SUB_8_IMM        = 5'b111??;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_LSL,
        ALU_LSR,
        ALU_ASR
    } alu_op_e;

    typedef enum logic [1:0] {
        FROM_REG,
        FROM_IMM,
        FROM_ZERO,
        FROM_ACCUMULATOR
    } operand_src_e;

    typedef enum logic {
        FROM_ALU,
        FROM_MEM
    } wb_src_e;

    // shift/arithmetic format, with the immediates laid over the register fields
    typedef union packed {
        struct packed {
            logic [1:0] op;
            logic [4:0] sub;
            logic [2:0] rm;
            logic [2:0] rn;
            logic [2:0] rd;
        } r3;
        struct packed {
            logic [1:0] op;
            logic [4:0] sub;
            logic [2:0] imm3;
            logic [2:0] rn;
            logic [2:0] rd;
        } i3;
        struct packed {
            logic [4:0] pre;
            logic [4:0] imm5;
            logic [2:0] rm;
            logic [2:0] rd;
        } i5;
        struct packed {
            logic [4:0] pre;
            logic [2:0] rd;
            logic [7:0] imm8;
        } i8;
    } arith_view_u;

    typedef struct packed {
        logic [4:0] op;
        logic [2:0] base;
        logic [7:0] reg_list;
    } mult_view_t;

    typedef union packed {
        arith_view_u arith;
        mult_view_t  mult;
    } instr_u;

endpackage

// ==== tb/tb_thumb_exec.sv ====
`timescale 1ns/1ps

module tb_thumb_exec import thumb_pkg::*; ();

    localparam int ARITH_ROUNDS = 12;
    localparam int SHIFT_ROUNDS = 8;
    localparam int MULTI_ROUNDS = 6;
    // an arithmetic round costs two 20-cycle budgets, a transfer round five
    localparam int TEST_COUNT = 2 + 2 * ARITH_ROUNDS + SHIFT_ROUNDS + 5 * MULTI_ROUNDS;

    logic                  clk_i = 1'b0;
    logic                  rst_i;
    instr_u                instr_i;
    logic                  instr_valid_i;
    logic                  stall_o;
    logic [ADDR_WIDTH-1:0] dbg_addr_i;
    logic [DATA_WIDTH-1:0] dbg_data_o;
    logic [3:0]            flags_o;

    // reference copy of the architectural state
    logic [31:0] m_regs [8];
    logic [31:0] m_mem [64];
    logic [3:0]  m_flags;

    always #4 clk_i = ~clk_i;

    thumb_exec_top uut (
        .clk_i, .rst_i, .instr_i, .instr_valid_i, .stall_o,
        .dbg_addr_i, .dbg_data_o, .flags_o
    );

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_failure(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    // holds the word until the rising edge that consumes it, counting stalled cycles
    task automatic send_instr(input instr_u word, input int exp_stall);
        int stalls;
        stalls = 0;
        @(negedge clk_i);
        instr_i       = word;
        instr_valid_i = 1'b1;
        #1;
        while (stall_o) begin
            stalls++;
            @(negedge clk_i);
            #1;
        end
        @(negedge clk_i);
        instr_valid_i = 1'b0;
        assert (stalls == exp_stall) else
            report_failure($sformatf("stall_o was high for %0d cycles instead of %0d",
                                     stalls, exp_stall));
    endtask

    task automatic check_state();
        for (int i = 0; i < 8; i++) begin
            @(negedge clk_i);
            dbg_addr_i = ADDR_WIDTH'(i);
            #1;
            assert (dbg_data_o === m_regs[i]) else
                report_mismatch($sformatf("dbg_data_o (r%0d)", i), dbg_data_o, m_regs[i]);
        end
        assert (flags_o === m_flags) else
            report_mismatch("flags_o", 32'(flags_o), 32'(m_flags));
        assert (stall_o === 1'b0) else
            report_failure("stall_o is high while no transfer is running");
    endtask

    // subtraction is done as a plus inverted b plus one, so carry out means no borrow
    task automatic model_add_sub(input logic [31:0] a, input logic [31:0] b,
                                 input bit subtract, input bit write, input int rd);
        logic [31:0] b_eff;
        logic [32:0] wide;
        b_eff = subtract ? ~b : b;
        wide  = {1'b0, a} + {1'b0, b_eff} + 33'(subtract);
        m_flags[3] = wide[31];
        m_flags[2] = (wide[31:0] == 32'd0);
        m_flags[1] = wide[32];
        m_flags[0] = (a[31] == b_eff[31]) && (wide[31] != a[31]);
        if (write) begin
            m_regs[rd] = wide[31:0];
        end
    endtask

    // kind is 100 MOV, 101 CMP, 110 ADD, 111 SUB
    task automatic exec_imm8(input logic [2:0] kind, input logic [2:0] rd,
                             input logic [7:0] imm);
        instr_u      w;
        logic [31:0] a;
        w = '0;
        w.arith.i8.pre  = {2'b00, kind};
        w.arith.i8.rd   = rd;
        w.arith.i8.imm8 = imm;
        send_instr(w, 0);
        a = (kind == 3'b100) ? 32'd0 : m_regs[rd];
        model_add_sub(a, 32'(imm), kind[0], kind != 3'b101, rd);
    endtask

    // variant bit 1 selects imm3 over rm, bit 0 selects subtraction
    task automatic exec_reg3(input logic [1:0] variant, input logic [2:0] rd,
                             input logic [2:0] rn, input logic [2:0] rm_imm);
        instr_u      w;
        logic [31:0] b;
        w = '0;
        w.arith.r3.sub = {3'b011, variant};
        w.arith.r3.rm  = rm_imm;
        w.arith.r3.rn  = rn;
        w.arith.r3.rd  = rd;
        send_instr(w, 0);
        b = variant[1] ? 32'(rm_imm) : m_regs[rm_imm];
        model_add_sub(m_regs[rn], b, variant[0], 1'b1, rd);
    endtask

    task automatic exec_shift(input logic [2:0] kind, input logic [2:0] rd,
                              input logic [2:0] rm, input logic [4:0] sh);
        instr_u      w;
        logic [31:0] a;
        logic [31:0] res;
        w = '0;
        w.arith.i5.pre  = {2'b00, kind};
        w.arith.i5.imm5 = sh;
        w.arith.i5.rm   = rm;
        w.arith.i5.rd   = rd;
        send_instr(w, 0);
        a = m_regs[rm];
        case (kind)
            3'b000:  res = a << sh;
            3'b001:  res = a >> sh;
            // arithmetic shift fills the vacated top bits with the sign
            default: res = (a >> sh) | ({32{a[31]}} & ~(32'hFFFF_FFFF >> sh));
        endcase
        m_regs[rd] = res;
        m_flags[3] = res[31];
        m_flags[2] = (res == 32'd0);
    endtask

    task automatic exec_multi(input bit load, input logic [2:0] base, input logic [7:0] list);
        instr_u w;
        int     moved;
        int     widx;
        w = '0;
        w.mult.op       = load ? LOAD_MULT_REG : STORE_MULT_REG;
        w.mult.base     = base;
        w.mult.reg_list = list;
        send_instr(w, 7);
        moved = 0;
        for (int k = 0; k < 8; k++) begin
            if (list[k]) begin
                widx = ((m_regs[base] + 4 * moved) / 4) % 64;
                if (load) begin
                    m_regs[k] = m_mem[widx];
                end else begin
                    m_mem[widx] = m_regs[k];
                end
                moved++;
            end
        end
    endtask

    // builds hi << 24 | lo so that the sign bit and the carry out get exercised
    task automatic load_value(input logic [2:0] rd, input logic [7:0] hi, input logic [7:0] lo);
        exec_imm8(3'b100, rd, hi);
        exec_shift(3'b000, rd, rd, 5'd24);
        exec_imm8(3'b110, rd, lo);
    endtask

    task automatic test_arith();
        logic [2:0] ra;
        logic [2:0] rb;
        logic [2:0] rd;
        repeat (ARITH_ROUNDS) begin
            ra = 3'($urandom_range(7));
            rb = 3'(ra + 1 + $urandom_range(6));
            rd = 3'($urandom_range(7));
            load_value(ra, 8'($urandom), 8'($urandom));
            load_value(rb, 8'($urandom), 8'($urandom));
            case ($urandom_range(6))
                0:       exec_reg3(2'b00, rd, ra, rb);
                1:       exec_reg3(2'b01, rd, ra, rb);
                2:       exec_reg3(2'b10, rd, ra, 3'($urandom));
                3:       exec_reg3(2'b11, rd, ra, 3'($urandom));
                4:       exec_imm8(3'b110, ra, 8'($urandom));
                5:       exec_imm8(3'b111, ra, 8'($urandom));
                default: exec_imm8(3'b101, ra, 8'($urandom));
            endcase
            check_state();
        end
    endtask

    task automatic test_shift();
        logic [2:0] rs;
        repeat (SHIFT_ROUNDS) begin
            rs = 3'($urandom_range(7));
            load_value(rs, 8'($urandom), 8'($urandom));
            exec_shift(3'($urandom_range(2)), 3'($urandom), rs, 5'($urandom));
            check_state();
        end
    endtask

    // the base stays out of the list so that LDM never moves its own address
    task automatic test_multi();
        logic [2:0] base;
        logic [7:0] list;
        repeat (MULTI_ROUNDS) begin
            base = 3'($urandom_range(7));
            list = 8'($urandom) & ~(8'd1 << base);
            exec_imm8(3'b100, base, 8'(4 * $urandom_range(47)));
            exec_multi(1'b0, base, list);
            for (int k = 0; k < 8; k++) begin
                if (list[k]) begin
                    exec_imm8(3'b100, 3'(k), 8'd0);
                end
            end
            exec_multi(1'b1, base, list);
            check_state();
        end
    endtask

    task automatic test_idle();
        instr_u w;
        @(negedge clk_i);
        w = '0;
        w.arith.i8.pre  = 5'b00100;
        w.arith.i8.imm8 = 8'h5A;
        instr_i       = w;
        instr_valid_i = 1'b0;
        repeat (3) @(negedge clk_i);
        check_state();
        w = 16'($urandom);
        w.mult.op = 5'b01000;
        send_instr(w, 0);
        w = 16'($urandom);
        w.mult.op = 5'b11101;
        send_instr(w, 0);
        check_state();
    endtask

    initial begin
        repeat (TEST_COUNT * 20) @(posedge clk_i);
        $display("Timeout after %0d cycles, the DUT stopped making progress", TEST_COUNT * 20);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(99));
        rst_i         = 1'b1;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        dbg_addr_i    = '0;
        m_flags       = '0;
        for (int i = 0; i < 8; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            m_mem[i] = '0;
        end
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        check_state();
        test_arith();
        test_shift();
        test_multi();
        test_idle();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
